// ==== opn_bus_pkg.sv ====
// OPN CPU bus definitions
// Host-side bus bundle, the per-cycle bus operation code and the
// layout of the status byte returned on every read

package opn_bus_pkg;

    // Host write port sampled once per clk
    typedef struct packed {
        logic       cs_n;   // Active-low chip select
        logic       wr_n;   // Active-low write strobe
        logic       a0;     // 0 selects address phase, 1 data phase
        logic [7:0] din;
    } cpu_bus_t;

    // What the bus is doing in a given cycle
    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_READ,
        BUS_ADDR_WR,
        BUS_DATA_WR
    } bus_op_e;

    // Status byte as seen by the host
    typedef struct packed {
        logic       busy;   // Bit 7
        logic [4:0] rsvd;   // Always zero
        logic       flag_b; // Bit 1
        logic       flag_a; // Bit 0
    } status_t;

endpackage

// ==== opn_bus_regs.sv ====
// OPN bus decoder and timer registers
// Splits host writes into address and data phases, keeps the register
// address latch, holds the timer values and control bits, and keeps the
// chip busy for a fixed number of clocks after each accepted data write

module opn_bus_regs #(
    parameter int BUSY_CYCLES = 32
) (
    input  logic                                clk,
    input  logic                                rst,
    input  opn_bus_pkg::cpu_bus_t               bus,
    output logic [opn_timer_pkg::TA_W-1:0]      ta_value,
    output logic [opn_timer_pkg::TB_W-1:0]      tb_value,
    output opn_timer_pkg::timer_ctrl_t          ctrl,
    output logic                                busy
);

    localparam int BW = $clog2(BUSY_CYCLES + 1);

    opn_bus_pkg::bus_op_e   op;
    logic [7:0]             addr_q;     // Last address phase value
    logic [BW-1:0]          busy_cnt;
    logic                   data_wr;    // Accepted data write

    // Classify this cycle's bus activity
    always_comb begin
        if (bus.cs_n) begin
            op = opn_bus_pkg::BUS_IDLE;
        end else if (bus.wr_n) begin
            op = opn_bus_pkg::BUS_READ;   // No side effect
        end else if (bus.a0) begin
            op = opn_bus_pkg::BUS_DATA_WR;
        end else begin
            op = opn_bus_pkg::BUS_ADDR_WR;
        end
    end

    assign data_wr = (op == opn_bus_pkg::BUS_DATA_WR) && !busy; // Dropped while busy

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_q <= 8'h00;
        end else if (op == opn_bus_pkg::BUS_ADDR_WR) begin
            addr_q <= bus.din;
        end
    end

    // Timer reload values
    always_ff @(posedge clk) begin
        if (rst) begin
            ta_value <= '0;
            tb_value <= '0;
        end else if (data_wr) begin
            case (addr_q)
                opn_timer_pkg::REG_TA_HI: ta_value[opn_timer_pkg::TA_W-1:2] <= bus.din;
                opn_timer_pkg::REG_TA_LO: begin
                    ta_value[opn_timer_pkg::TA_LO_W-1:0] <=
                        bus.din[opn_timer_pkg::TA_LO_W-1:0];
                end
                opn_timer_pkg::REG_TB:    tb_value <= bus.din;
                default: ;
            endcase
        end
    end

    // Clear bits only live for one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl <= '0;
        end else begin
            ctrl.clr_a <= 1'b0;
            ctrl.clr_b <= 1'b0;
            if (data_wr && addr_q == opn_timer_pkg::REG_TCTRL) begin
                ctrl <= opn_timer_pkg::timer_ctrl_t'(bus.din[opn_timer_pkg::TCTRL_W-1:0]);
            end
        end
    end

    // Busy window counts down from the accepted write
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy_cnt <= BW'(BUSY_CYCLES);
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    assign busy = (busy_cnt != '0);

    // Busy only ever starts from a data phase write
    a_busy_from_write: assert property (
        @(posedge clk) disable iff (rst)
        $rose(busy) |-> $past(op == opn_bus_pkg::BUS_DATA_WR)
    );

    a_clr_a_pulse: assert property (
        @(posedge clk) disable iff (rst)
        ctrl.clr_a |=> !ctrl.clr_a
    );

    a_clr_b_pulse: assert property (
        @(posedge clk) disable iff (rst)
        ctrl.clr_b |=> !ctrl.clr_b
    );

endmodule

// ==== opn_sample_tick.sv ====
// Sample rate prescaler
// Counts external clock enable pulses and issues a single-cycle tick
// once every SAMPLE_DIV of them

module opn_sample_tick #(
    parameter int SAMPLE_DIV = 144
) (
    input  logic clk,
    input  logic rst,
    input  logic cen,
    output logic tick
);

    localparam int CW = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;

    logic [CW-1:0] cen_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cen_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            tick <= 1'b0;
            if (cen) begin
                if (cen_cnt == CW'(SAMPLE_DIV - 1)) begin
                    cen_cnt <= '0;
                    tick    <= 1'b1;    // End of sample period
                end else begin
                    cen_cnt <= cen_cnt + 1'b1;
                end
            end
        end
    end

    a_tick_single: assert property (
        @(posedge clk) disable iff (rst)
        tick |=> !tick
    );

endmodule

// ==== opn_status.sv ====
// Timer flags and status byte
// Flags set on an enabled overflow and clear on a clear pulse. The
// status byte combines busy with both flags, and irq_n is low while
// either flag is set

module opn_status (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        ovf_a,
    input  logic                        ovf_b,
    input  logic                        busy,
    input  opn_timer_pkg::timer_ctrl_t  ctrl,
    output opn_bus_pkg::status_t        status,
    output logic                        irq_n
);

    logic flag_a;
    logic flag_b;

    // Clear wins over a same-cycle overflow
    always_ff @(posedge clk) begin
        if (rst) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else begin
            if (ctrl.clr_a) begin
                flag_a <= 1'b0;
            end else if (ovf_a && ctrl.en_a) begin
                flag_a <= 1'b1;
            end
            if (ctrl.clr_b) begin
                flag_b <= 1'b0;
            end else if (ovf_b && ctrl.en_b) begin
                flag_b <= 1'b1;
            end
        end
    end

    always_comb begin
        status        = '0;
        status.busy   = busy;
        status.flag_b = flag_b;
        status.flag_a = flag_a;
    end

    assign irq_n = !(flag_a || flag_b);     // Active low

    a_flag_a_enabled: assert property (
        @(posedge clk) disable iff (rst)
        $rose(flag_a) |-> $past(ctrl.en_a)
    );

    a_flag_b_enabled: assert property (
        @(posedge clk) disable iff (rst)
        $rose(flag_b) |-> $past(ctrl.en_b)
    );

endmodule

// ==== opn_timer.sv ====
// Reloading timer
// Up-counter that starts from value while load is set and counts one
// step per count tick. A count tick is SUBDIV sample ticks. Passing the
// maximum gives a one-cycle overflow pulse and reloads value, so one
// period is 2^WIDTH - value count ticks

module opn_timer #(
    parameter int WIDTH  = 10,
    parameter int SUBDIV = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             tick,
    input  logic             load,
    input  logic [WIDTH-1:0] value,
    output logic             overflow
);

    logic             cnt_tick;   // One counter step
    logic [WIDTH-1:0] cnt;
    logic             wrap;

    // Optional pre-divider, restarts with the timer
    if (SUBDIV > 1) begin : g_subdiv
        localparam int SW = $clog2(SUBDIV);

        logic [SW-1:0] sub_cnt;

        always_ff @(posedge clk) begin
            if (rst || !load) begin
                sub_cnt <= '0;
            end else if (tick) begin
                if (sub_cnt == SW'(SUBDIV - 1)) begin
                    sub_cnt <= '0;
                end else begin
                    sub_cnt <= sub_cnt + 1'b1;
                end
            end
        end

        assign cnt_tick = tick && (sub_cnt == SW'(SUBDIV - 1));
    end else begin : g_no_subdiv
        assign cnt_tick = tick;
    end

    assign wrap = cnt_tick && (&cnt);   // Step past all ones

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt      <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= load && wrap;
            if (!load || wrap) begin
                cnt <= value;           // Stopped timers track the value
            end else if (cnt_tick) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    a_ovf_needs_load: assert property (
        @(posedge clk) disable iff (rst)
        overflow |-> $past(load)
    );

endmodule

// ==== opn_timer_pkg.sv ====
// OPN timer definitions
// Register map of the timer block, the control bits written through
// register 0x27 and the widths of timer A and timer B

package opn_timer_pkg;

    // Counter widths
    localparam int TA_W = 10;
    localparam int TB_W = 8;

    // Timer register addresses in the FM register space
    typedef enum logic [7:0] {
        REG_TA_HI = 8'h24,  // Timer A value bits 9..2
        REG_TA_LO = 8'h25,  // Timer A value bits 1..0
        REG_TB    = 8'h26,  // Timer B value
        REG_TCTRL = 8'h27   // Load, enable and clear bits
    } reg_addr_e;

    // Timer control as written to REG_TCTRL
    // Field order puts load_a at data bit 0
    typedef struct packed {
        logic clr_b;    // Pulse, clears flag B
        logic clr_a;    // Pulse, clears flag A
        logic en_b;     // Flag B may set on overflow
        logic en_a;     // Flag A may set on overflow
        logic load_b;   // Timer B runs while set
        logic load_a;   // Timer A runs while set
    } timer_ctrl_t;

    // Number of control bits taken from the data byte
    localparam int TCTRL_W = $bits(timer_ctrl_t);

    // Low part of timer A lives in its own register
    localparam int TA_LO_W = TA_W - 8;

endpackage

// ==== opn_timers.sv ====
// OPN timer slice, top level
// Host register port, sample prescaler, timers A and B and the status
// and interrupt logic of a YM2612-style FM chip

module opn_timers #(
    parameter int SAMPLE_DIV  = 144,
    parameter int BUSY_CYCLES = 32,
    parameter int TB_SUBDIV   = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  opn_bus_pkg::cpu_bus_t   bus,
    output opn_bus_pkg::status_t    dout,
    output logic                    irq_n
);

    logic [opn_timer_pkg::TA_W-1:0]     ta_value;
    logic [opn_timer_pkg::TB_W-1:0]     tb_value;
    opn_timer_pkg::timer_ctrl_t         ctrl;
    logic                               busy;
    logic                               tick;
    logic                               ovf_a;
    logic                               ovf_b;

    opn_bus_regs #(.BUSY_CYCLES(BUSY_CYCLES)) u_bus_regs (
        .clk        ( clk       ),
        .rst        ( rst       ),
        .bus        ( bus       ),
        .ta_value   ( ta_value  ),
        .tb_value   ( tb_value  ),
        .ctrl       ( ctrl      ),
        .busy       ( busy      )
    );

    opn_sample_tick #(.SAMPLE_DIV(SAMPLE_DIV)) u_sample_tick (
        .clk    ( clk   ),
        .rst    ( rst   ),
        .cen    ( cen   ),
        .tick   ( tick  )
    );

    // Timer A counts every sample
    opn_timer #(.WIDTH(opn_timer_pkg::TA_W), .SUBDIV(1)) u_timer_a (
        .clk        ( clk           ),
        .rst        ( rst           ),
        .tick       ( tick          ),
        .load       ( ctrl.load_a   ),
        .value      ( ta_value      ),
        .overflow   ( ovf_a         )
    );

    opn_timer #(.WIDTH(opn_timer_pkg::TB_W), .SUBDIV(TB_SUBDIV)) u_timer_b (
        .clk        ( clk           ),
        .rst        ( rst           ),
        .tick       ( tick          ),
        .load       ( ctrl.load_b   ),
        .value      ( tb_value      ),
        .overflow   ( ovf_b         )
    );

    opn_status u_status (
        .clk    ( clk   ),
        .rst    ( rst   ),
        .ovf_a  ( ovf_a ),
        .ovf_b  ( ovf_b ),
        .busy   ( busy  ),
        .ctrl   ( ctrl  ),
        .status ( dout  ),
        .irq_n  ( irq_n )
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the timer slice testbench with Verilator and run it.
# The run counts as passed only if the pass message shows up in the output.
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_opn_timers -o tb_opn_timers_sim &&
./obj_dir/tb_opn_timers_sim | tee /dev/stderr | grep -q "all tests passed" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

// ==== tb_opn_timers.sv ====
// Testbench for the OPN timer slice
// Drives the host bus, models the busy window from the bus rules and
// checks the status byte and irq_n with concurrent assertions

module tb_opn_timers;

    localparam int SAMPLE_DIV  = 4;
    localparam int BUSY_CYCLES = 32;
    localparam int TB_SUBDIV   = 16;
    localparam int POLL_LIMIT  = 200;

    logic                   clk;
    logic                   rst;
    logic                   cen;
    opn_bus_pkg::cpu_bus_t  bus;
    opn_bus_pkg::status_t   dout;
    logic                   irq_n;

    int         busy_left;      // Expected busy cycles still to come
    logic       wrote_any;
    logic       allow_flag_a;   // Flag A may be set
    logic       allow_flag_b;
    logic       clr_a_wr;       // Clear A write on the bus
    logic       clr_a_seen;
    string      test_name;
    int         err_count;
    int         err_at_start;
    int         tests_run;
    int         tests_ok;
    int         ta_val;
    int         tb_val;

    opn_timers #(
        .SAMPLE_DIV     ( SAMPLE_DIV    ),
        .BUSY_CYCLES    ( BUSY_CYCLES   ),
        .TB_SUBDIV      ( TB_SUBDIV     )
    ) opn_timers_i (
        .clk    ( clk   ),
        .rst    ( rst   ),
        .cen    ( cen   ),
        .bus    ( bus   ),
        .dout   ( dout  ),
        .irq_n  ( irq_n )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Expected busy window from accepted data writes
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_left  <= 0;
            clr_a_seen <= 1'b0;
        end else begin
            clr_a_seen <= clr_a_wr;
            if (!bus.cs_n && !bus.wr_n && bus.a0 && busy_left == 0) begin
                busy_left <= BUSY_CYCLES;
            end else if (busy_left != 0) begin
                busy_left <= busy_left - 1;
            end
        end
    end

    task automatic report_mismatch(input string what, input int expected, input int actual);
        $display("FAILED %s %s: expected %0h actual %0h", test_name, what, expected, actual);
        err_count++;
    endtask

    a_reset_dout: assert property (@(posedge clk) disable iff (rst)
        !wrote_any |-> dout == 8'h00)
        else report_mismatch("dout", 0, int'($sampled(dout)));

    a_reset_irq: assert property (@(posedge clk) disable iff (rst)
        !wrote_any |-> irq_n)
        else report_mismatch("irq_n", 1, int'($sampled(irq_n)));

    a_busy_window: assert property (@(posedge clk) disable iff (rst)
        dout.busy == (busy_left != 0))
        else report_mismatch("busy", ($sampled(busy_left) != 0) ? 1 : 0,
                             int'($sampled(dout.busy)));

    // Low in the same cycle as either flag
    a_irq_flags: assert property (@(posedge clk) disable iff (rst)
        irq_n == !(dout.flag_a || dout.flag_b))
        else report_mismatch("irq_n", int'(!($sampled(dout.flag_a) || $sampled(dout.flag_b))),
                             int'($sampled(irq_n)));

    a_quiet_a: assert property (@(posedge clk) disable iff (rst)
        !allow_flag_a |-> !dout.flag_a)
        else report_mismatch("flag_a", 0, 1);

    a_quiet_b: assert property (@(posedge clk) disable iff (rst)
        !allow_flag_b |-> !dout.flag_b)
        else report_mismatch("flag_b", 0, 1);

    a_clear_a: assert property (@(posedge clk) disable iff (rst)
        clr_a_seen |=> (!dout.flag_a && irq_n))
        else report_mismatch("flag_a,irq_n", 1, int'({$sampled(dout.flag_a), $sampled(irq_n)}));

    // One write cycle then the bus idles from the next falling edge
    task automatic bus_cycle(input logic a0, input logic [7:0] din, input logic clr_mark);
        bus       = '{cs_n: 1'b0, wr_n: 1'b0, a0: a0, din: din};
        clr_a_wr  = clr_mark;
        wrote_any = 1'b1;
        @(negedge clk);
        bus      = '{cs_n: 1'b1, wr_n: 1'b1, a0: 1'b0, din: 8'h00};
        clr_a_wr = 1'b0;
    endtask

    task automatic wait_not_busy();
        int n;
        n = 0;
        while (dout.busy && n < POLL_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (dout.busy) begin
            $display("%s: busy stayed high for %0d cycles", test_name, POLL_LIMIT);
            err_count++;
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        bus_cycle(1'b0, addr, 1'b0);
        wait_not_busy();
        bus_cycle(1'b1, data, addr == opn_timer_pkg::REG_TCTRL && data[4]);
    endtask

    task automatic wait_flag(input logic which_b, input logic level, input int max_cycles);
        int n;
        n = 0;
        while ((which_b ? dout.flag_b : dout.flag_a) != level && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if ((which_b ? dout.flag_b : dout.flag_a) != level) begin
            $display("%s: flag %s did not go to %0b within %0d cycles",
                     test_name, which_b ? "B" : "A", level, max_cycles);
            err_count++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name    = name;
        err_at_start = err_count;
        tests_run++;
    endtask

    task automatic end_test();
        if (err_count == err_at_start) begin
            tests_ok++;
            $display("test %s ok", test_name);
        end else begin
            $display("test %s: %0d check(s) failed", test_name, err_count - err_at_start);
        end
    endtask

    initial begin
        rst          = 1'b1;
        cen          = 1'b1;
        bus          = '{cs_n: 1'b1, wr_n: 1'b1, a0: 1'b0, din: 8'h00};
        wrote_any    = 1'b0;
        allow_flag_a = 1'b0;
        allow_flag_b = 1'b0;
        clr_a_wr     = 1'b0;
        test_name    = "setup";
        err_count    = 0;
        err_at_start = 0;
        tests_run    = 0;
        tests_ok     = 0;
        void'($urandom(32'h2231));
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        begin_test("reset_state");
        repeat (10) @(negedge clk);
        end_test();

        begin_test("busy");
        bus_cycle(1'b0, opn_timer_pkg::REG_TA_HI, 1'b0);
        repeat (4) @(negedge clk);                  // Address phase alone
        bus_cycle(1'b1, 8'hff, 1'b0);
        bus_cycle(1'b1, 8'h00, 1'b0);               // Dropped while busy
        wait_not_busy();
        end_test();

        begin_test("timer_a_flag");
        ta_val = 1016 + int'($urandom % 8);         // Short periods
        write_reg(opn_timer_pkg::REG_TA_HI, 8'(ta_val >> 2));
        write_reg(opn_timer_pkg::REG_TA_LO, 8'(ta_val & 3));
        allow_flag_a = 1'b1;
        write_reg(opn_timer_pkg::REG_TCTRL, 8'h05); // load_a and en_a
        wait_flag(1'b0, 1'b1, (1024 - ta_val + 1) * SAMPLE_DIV);
        end_test();

        begin_test("flag_clear");
        write_reg(opn_timer_pkg::REG_TCTRL, 8'h15); // clr_a while timer A keeps running
        wait_flag(1'b0, 1'b0, 4);
        wait_flag(1'b0, 1'b1, (1024 - ta_val + 1) * SAMPLE_DIV);
        end_test();

        begin_test("timer_b_flag");
        tb_val = 250 + int'($urandom % 6);
        write_reg(opn_timer_pkg::REG_TB, 8'(tb_val));
        // Stop A and clear its flag while B starts
        write_reg(opn_timer_pkg::REG_TCTRL, 8'h1a);
        wait_flag(1'b0, 1'b0, 4);
        allow_flag_a = 1'b0;
        allow_flag_b = 1'b1;
        wait_flag(1'b1, 1'b1, (256 - tb_val + 1) * TB_SUBDIV * SAMPLE_DIV);
        end_test();

        begin_test("masked_overflow");
        write_reg(opn_timer_pkg::REG_TCTRL, 8'h21); // load_a and clr_b
        wait_flag(1'b1, 1'b0, 4);
        allow_flag_b = 1'b0;
        repeat ((3 * (1024 - ta_val) + 1) * SAMPLE_DIV) @(negedge clk);
        end_test();

        $display("%0d of %0d tests ok, %0d failed checks", tests_ok, tests_run, err_count);
        if (err_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
opn_bus_pkg.sv
opn_timer_pkg.sv
opn_bus_regs.sv
opn_sample_tick.sv
opn_timer.sv
opn_status.sv
opn_timers.sv
tb_opn_timers.sv
